//--- common/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus widths
`define SOC_ADDR_W     32
`define SOC_DATA_W     64
`define SOC_STRB_W     8
`define SOC_ID_W       4

// main RAM window, 64 KB
`define SOC_RAM_BASE   32'h1c00_0000
`define SOC_RAM_AW     16

// display buffer window, 2 KB
`define SOC_VGA_BASE   32'h0001_0000
`define SOC_VGA_AW     11

// peripheral scratch window, 64 KB
`define SOC_PERI_BASE  32'h0002_0000
`define SOC_PERI_AW    16

`endif

//--- common/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   typedef struct packed {
      logic [`SOC_ID_W-1:0]   id;
      logic [`SOC_ADDR_W-1:0] addr;
   } axi_aw_t;

   typedef struct packed {
      logic [`SOC_DATA_W-1:0] data;
      logic [`SOC_STRB_W-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [`SOC_ID_W-1:0]   id;
      axi_resp_e              resp;
   } axi_b_t;

   typedef struct packed {
      logic [`SOC_ID_W-1:0]   id;
      logic [`SOC_ADDR_W-1:0] addr;
   } axi_ar_t;

   typedef struct packed {
      logic [`SOC_ID_W-1:0]   id;
      logic [`SOC_DATA_W-1:0] data;
      axi_resp_e              resp;
   } axi_r_t;

   // decoded target window
   typedef enum logic [1:0] {
      SEL_RAM,
      SEL_VGA,
      SEL_PERI,
      SEL_NONE
   } slave_sel_e;

endpackage

//--- verilog/sram_bank.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module sram_bank #(
   parameter int DEPTH_WORDS = 8192
)
(
   input  logic                           clk,
   input  logic                           ren,
   input  logic [$clog2(DEPTH_WORDS)-1:0] raddr,
   output logic [`SOC_DATA_W-1:0]         rdata,
   input  logic [`SOC_STRB_W-1:0]         wen,
   input  logic [$clog2(DEPTH_WORDS)-1:0] waddr,
   input  logic [`SOC_DATA_W-1:0]         wdata
);

   logic [`SOC_DATA_W-1:0] mem [DEPTH_WORDS];

   // byte lane writes
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `SOC_STRB_W; i++)
      begin
         if (wen[i])
            mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
   end

   // read data shows up the cycle after ren and then holds
   always_ff @(posedge clk)
   begin
      if (ren)
         rdata <= mem[raddr];
   end

endmodule

//--- sram_bridge/axi_sram_bridge.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axi_sram_bridge
   import soc_pkg::*;
#(
   parameter int WIN_AW = 16
)
(
   input  logic                   clk,
   input  logic                   resetn,
   input  axi_aw_t                s_aw,
   input  logic                   s_aw_valid,
   output logic                   s_aw_ready,
   input  axi_w_t                 s_w,
   input  logic                   s_w_valid,
   output logic                   s_w_ready,
   output axi_b_t                 s_b,
   output logic                   s_b_valid,
   input  logic                   s_b_ready,
   input  axi_ar_t                s_ar,
   input  logic                   s_ar_valid,
   output logic                   s_ar_ready,
   output axi_r_t                 s_r,
   output logic                   s_r_valid,
   input  logic                   s_r_ready,
   output logic                   ren,
   output logic [WIN_AW-4:0]      raddr,
   input  logic [`SOC_DATA_W-1:0] rdata,
   output logic [`SOC_STRB_W-1:0] wen,
   output logic [WIN_AW-4:0]      waddr,
   output logic [`SOC_DATA_W-1:0] wdata
);

   typedef enum logic [1:0] {
      IDLE,
      READ_WAIT,
      WRITE_RESP,
      READ_RESP
   } state_e;

   state_e               state;
   logic [`SOC_ID_W-1:0] id_q;
   logic                 wr_acc;
   logic                 rd_acc;

   // AW and W are taken together, a write beats a read
   assign wr_acc = (state == IDLE) && s_aw_valid && s_w_valid;
   assign rd_acc = (state == IDLE) && s_ar_valid && !(s_aw_valid && s_w_valid);

   assign s_aw_ready = wr_acc;
   assign s_w_ready  = wr_acc;
   assign s_ar_ready = rd_acc;

   // bank is accessed on the acceptance edge
   assign wen   = wr_acc ? s_w.strb : '0;
   assign waddr = s_aw.addr[WIN_AW-1:3];
   assign wdata = s_w.data;
   assign ren   = rd_acc;
   assign raddr = s_ar.addr[WIN_AW-1:3];

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         state <= IDLE;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (wr_acc)
                  state <= WRITE_RESP;
               else if (rd_acc)
                  state <= READ_WAIT;
            end
            READ_WAIT:
               state <= READ_RESP;
            WRITE_RESP:
            begin
               if (s_b_ready)
                  state <= IDLE;
            end
            READ_RESP:
            begin
               if (s_r_ready)
                  state <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_acc)
         id_q <= s_aw.id;
      else if (rd_acc)
         id_q <= s_ar.id;
   end

   assign s_b_valid = (state == WRITE_RESP);
   assign s_b       = '{id: id_q, resp: OKAY};

   // bank output stays put until the next ren so it can feed R directly
   assign s_r_valid = (state == READ_RESP);
   assign s_r       = '{id: id_q, data: rdata, resp: OKAY};

   a_no_rw_collision: assert property (@(posedge clk) disable iff (!resetn)
      !(ren && (|wen)));

endmodule

//--- interconnect/axi_interconnect.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axi_interconnect
   import soc_pkg::*;
(
   input  logic    clk,
   input  logic    resetn,
   input  axi_aw_t m_aw,
   input  logic    m_aw_valid,
   output logic    m_aw_ready,
   input  axi_w_t  m_w,
   input  logic    m_w_valid,
   output logic    m_w_ready,
   output axi_b_t  m_b,
   output logic    m_b_valid,
   input  logic    m_b_ready,
   input  axi_ar_t m_ar,
   input  logic    m_ar_valid,
   output logic    m_ar_ready,
   output axi_r_t  m_r,
   output logic    m_r_valid,
   input  logic    m_r_ready,
   // main RAM
   output axi_aw_t s_ram_aw,
   output logic    s_ram_aw_valid,
   input  logic    s_ram_aw_ready,
   output axi_w_t  s_ram_w,
   output logic    s_ram_w_valid,
   input  logic    s_ram_w_ready,
   input  axi_b_t  s_ram_b,
   input  logic    s_ram_b_valid,
   output logic    s_ram_b_ready,
   output axi_ar_t s_ram_ar,
   output logic    s_ram_ar_valid,
   input  logic    s_ram_ar_ready,
   input  axi_r_t  s_ram_r,
   input  logic    s_ram_r_valid,
   output logic    s_ram_r_ready,
   // display buffer
   output axi_aw_t s_vga_aw,
   output logic    s_vga_aw_valid,
   input  logic    s_vga_aw_ready,
   output axi_w_t  s_vga_w,
   output logic    s_vga_w_valid,
   input  logic    s_vga_w_ready,
   input  axi_b_t  s_vga_b,
   input  logic    s_vga_b_valid,
   output logic    s_vga_b_ready,
   output axi_ar_t s_vga_ar,
   output logic    s_vga_ar_valid,
   input  logic    s_vga_ar_ready,
   input  axi_r_t  s_vga_r,
   input  logic    s_vga_r_valid,
   output logic    s_vga_r_ready,
   // peripheral scratch
   output axi_aw_t s_peri_aw,
   output logic    s_peri_aw_valid,
   input  logic    s_peri_aw_ready,
   output axi_w_t  s_peri_w,
   output logic    s_peri_w_valid,
   input  logic    s_peri_w_ready,
   input  axi_b_t  s_peri_b,
   input  logic    s_peri_b_valid,
   output logic    s_peri_b_ready,
   output axi_ar_t s_peri_ar,
   output logic    s_peri_ar_valid,
   input  logic    s_peri_ar_ready,
   input  axi_r_t  s_peri_r,
   input  logic    s_peri_r_valid,
   output logic    s_peri_r_ready
);

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      WAIT_RESP,
      RESPOND
   } state_e;

   state_e     state;
   slave_sel_e sel_q;
   logic       is_wr_q;
   axi_aw_t    req_q;
   axi_w_t     w_q;
   axi_b_t     b_q;
   axi_r_t     r_q;
   axi_ar_t    ar_req;
   logic       wr_acc;
   logic       rd_acc;
   slave_sel_e acc_sel;
   logic [2:0] hit;
   logic       issue_wr;
   logic       issue_rd;
   logic       take_b;
   logic       take_r;
   logic       req_taken;
   logic       rsp_valid;
   logic       rsp_done;
   axi_b_t     b_mux;
   axi_r_t     r_mux;

   // window hit when the bits above the window size match the base
   function automatic slave_sel_e decode(input logic [`SOC_ADDR_W-1:0] addr);
      if ((addr >> `SOC_RAM_AW) == (`SOC_RAM_BASE >> `SOC_RAM_AW))
         return SEL_RAM;
      else if ((addr >> `SOC_VGA_AW) == (`SOC_VGA_BASE >> `SOC_VGA_AW))
         return SEL_VGA;
      else if ((addr >> `SOC_PERI_AW) == (`SOC_PERI_BASE >> `SOC_PERI_AW))
         return SEL_PERI;
      else
         return SEL_NONE;
   endfunction

   // write wins over a read in the same idle cycle
   assign wr_acc  = (state == IDLE) && m_aw_valid && m_w_valid;
   assign rd_acc  = (state == IDLE) && m_ar_valid && !(m_aw_valid && m_w_valid);
   assign acc_sel = decode(wr_acc ? m_aw.addr : m_ar.addr);

   assign m_aw_ready = wr_acc;
   assign m_w_ready  = wr_acc;
   assign m_ar_ready = rd_acc;

   assign hit[0] = (sel_q == SEL_RAM);
   assign hit[1] = (sel_q == SEL_VGA);
   assign hit[2] = (sel_q == SEL_PERI);

   assign issue_wr = (state == ISSUE) && is_wr_q;
   assign issue_rd = (state == ISSUE) && !is_wr_q;
   assign take_b   = (state == WAIT_RESP) && is_wr_q;
   assign take_r   = (state == WAIT_RESP) && !is_wr_q;

   assign req_taken = is_wr_q ?
      |(hit & {s_peri_aw_ready && s_peri_w_ready,
               s_vga_aw_ready && s_vga_w_ready,
               s_ram_aw_ready && s_ram_w_ready}) :
      |(hit & {s_peri_ar_ready, s_vga_ar_ready, s_ram_ar_ready});
   assign rsp_valid = is_wr_q ?
      |(hit & {s_peri_b_valid, s_vga_b_valid, s_ram_b_valid}) :
      |(hit & {s_peri_r_valid, s_vga_r_valid, s_ram_r_valid});
   assign rsp_done  = (state == WAIT_RESP) && rsp_valid;

   always_comb
   begin
      case (sel_q)
         SEL_VGA:
         begin
            b_mux = s_vga_b;
            r_mux = s_vga_r;
         end
         SEL_PERI:
         begin
            b_mux = s_peri_b;
            r_mux = s_peri_r;
         end
         default:
         begin
            b_mux = s_ram_b;
            r_mux = s_ram_r;
         end
      endcase
   end

   // request payload is broadcast and only the selected valid rises
   assign ar_req = '{id: req_q.id, addr: req_q.addr};

   assign s_ram_aw        = req_q;
   assign s_ram_aw_valid  = issue_wr && hit[0];
   assign s_ram_w         = w_q;
   assign s_ram_w_valid   = issue_wr && hit[0];
   assign s_ram_ar        = ar_req;
   assign s_ram_ar_valid  = issue_rd && hit[0];
   assign s_ram_b_ready   = take_b && hit[0];
   assign s_ram_r_ready   = take_r && hit[0];

   assign s_vga_aw        = req_q;
   assign s_vga_aw_valid  = issue_wr && hit[1];
   assign s_vga_w         = w_q;
   assign s_vga_w_valid   = issue_wr && hit[1];
   assign s_vga_ar        = ar_req;
   assign s_vga_ar_valid  = issue_rd && hit[1];
   assign s_vga_b_ready   = take_b && hit[1];
   assign s_vga_r_ready   = take_r && hit[1];

   assign s_peri_aw       = req_q;
   assign s_peri_aw_valid = issue_wr && hit[2];
   assign s_peri_w        = w_q;
   assign s_peri_w_valid  = issue_wr && hit[2];
   assign s_peri_ar       = ar_req;
   assign s_peri_ar_valid = issue_rd && hit[2];
   assign s_peri_b_ready  = take_b && hit[2];
   assign s_peri_r_ready  = take_r && hit[2];

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         state   <= IDLE;
         sel_q   <= SEL_NONE;
         is_wr_q <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (wr_acc || rd_acc)
               begin
                  sel_q   <= acc_sel;
                  is_wr_q <= wr_acc;
                  // unmapped requests go straight to the response
                  if (acc_sel == SEL_NONE)
                     state <= RESPOND;
                  else
                     state <= ISSUE;
               end
            end
            ISSUE:
            begin
               if (req_taken)
                  state <= WAIT_RESP;
            end
            WAIT_RESP:
            begin
               if (rsp_valid)
                  state <= RESPOND;
            end
            RESPOND:
            begin
               if (is_wr_q ? m_b_ready : m_r_ready)
                  state <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // DECERR is preloaded and the bridge response replaces it for mapped targets
   always_ff @(posedge clk)
   begin
      if (wr_acc)
      begin
         req_q <= m_aw;
         w_q   <= m_w;
         b_q   <= '{id: m_aw.id, resp: DECERR};
      end
      else if (rd_acc)
      begin
         req_q <= '{id: m_ar.id, addr: m_ar.addr};
         r_q   <= '{id: m_ar.id, data: '0, resp: DECERR};
      end
      else if (rsp_done)
      begin
         b_q <= b_mux;
         r_q <= r_mux;
      end
   end

   assign m_b       = b_q;
   assign m_r       = r_q;
   assign m_b_valid = (state == RESPOND) && is_wr_q;
   assign m_r_valid = (state == RESPOND) && !is_wr_q;

   a_one_slave: assert property (@(posedge clk) disable iff (!resetn)
      $onehot0({s_ram_b_valid, s_ram_r_valid, s_vga_b_valid,
                s_vga_r_valid, s_peri_b_valid, s_peri_r_valid}));

   a_one_resp: assert property (@(posedge clk) disable iff (!resetn)
      !(m_b_valid && m_r_valid));

endmodule

//--- verilog/soc_top.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_top
   import soc_pkg::*;
(
   input  logic    clk,
   input  logic    resetn,
   input  axi_aw_t m_aw,
   input  logic    m_aw_valid,
   output logic    m_aw_ready,
   input  axi_w_t  m_w,
   input  logic    m_w_valid,
   output logic    m_w_ready,
   output axi_b_t  m_b,
   output logic    m_b_valid,
   input  logic    m_b_ready,
   input  axi_ar_t m_ar,
   input  logic    m_ar_valid,
   output logic    m_ar_ready,
   output axi_r_t  m_r,
   output logic    m_r_valid,
   input  logic    m_r_ready
);

   // index 0 ram, 1 vga, 2 peri
   localparam int WIN_AW [3] = '{`SOC_RAM_AW, `SOC_VGA_AW, `SOC_PERI_AW};

   axi_aw_t    s_aw [3];
   axi_w_t     s_w [3];
   axi_b_t     s_b [3];
   axi_ar_t    s_ar [3];
   axi_r_t     s_r [3];
   logic [2:0] s_aw_valid;
   logic [2:0] s_aw_ready;
   logic [2:0] s_w_valid;
   logic [2:0] s_w_ready;
   logic [2:0] s_b_valid;
   logic [2:0] s_b_ready;
   logic [2:0] s_ar_valid;
   logic [2:0] s_ar_ready;
   logic [2:0] s_r_valid;
   logic [2:0] s_r_ready;

   axi_interconnect ic_i (
      .*,
      .s_ram_aw        (s_aw[0]),
      .s_ram_aw_valid  (s_aw_valid[0]),
      .s_ram_aw_ready  (s_aw_ready[0]),
      .s_ram_w         (s_w[0]),
      .s_ram_w_valid   (s_w_valid[0]),
      .s_ram_w_ready   (s_w_ready[0]),
      .s_ram_b         (s_b[0]),
      .s_ram_b_valid   (s_b_valid[0]),
      .s_ram_b_ready   (s_b_ready[0]),
      .s_ram_ar        (s_ar[0]),
      .s_ram_ar_valid  (s_ar_valid[0]),
      .s_ram_ar_ready  (s_ar_ready[0]),
      .s_ram_r         (s_r[0]),
      .s_ram_r_valid   (s_r_valid[0]),
      .s_ram_r_ready   (s_r_ready[0]),
      .s_vga_aw        (s_aw[1]),
      .s_vga_aw_valid  (s_aw_valid[1]),
      .s_vga_aw_ready  (s_aw_ready[1]),
      .s_vga_w         (s_w[1]),
      .s_vga_w_valid   (s_w_valid[1]),
      .s_vga_w_ready   (s_w_ready[1]),
      .s_vga_b         (s_b[1]),
      .s_vga_b_valid   (s_b_valid[1]),
      .s_vga_b_ready   (s_b_ready[1]),
      .s_vga_ar        (s_ar[1]),
      .s_vga_ar_valid  (s_ar_valid[1]),
      .s_vga_ar_ready  (s_ar_ready[1]),
      .s_vga_r         (s_r[1]),
      .s_vga_r_valid   (s_r_valid[1]),
      .s_vga_r_ready   (s_r_ready[1]),
      .s_peri_aw       (s_aw[2]),
      .s_peri_aw_valid (s_aw_valid[2]),
      .s_peri_aw_ready (s_aw_ready[2]),
      .s_peri_w        (s_w[2]),
      .s_peri_w_valid  (s_w_valid[2]),
      .s_peri_w_ready  (s_w_ready[2]),
      .s_peri_b        (s_b[2]),
      .s_peri_b_valid  (s_b_valid[2]),
      .s_peri_b_ready  (s_b_ready[2]),
      .s_peri_ar       (s_ar[2]),
      .s_peri_ar_valid (s_ar_valid[2]),
      .s_peri_ar_ready (s_ar_ready[2]),
      .s_peri_r        (s_r[2]),
      .s_peri_r_valid  (s_r_valid[2]),
      .s_peri_r_ready  (s_r_ready[2])
   );

   // one bridge and bank pair per window
   for (genvar i = 0; i < 3; i++)
   begin : g_win
      logic                   ren;
      logic [WIN_AW[i]-4:0]   raddr;
      logic [`SOC_DATA_W-1:0] rdata;
      logic [`SOC_STRB_W-1:0] wen;
      logic [WIN_AW[i]-4:0]   waddr;
      logic [`SOC_DATA_W-1:0] wdata;

      axi_sram_bridge #(
         .WIN_AW (WIN_AW[i])
      ) bridge_i (
         .clk        (clk),
         .resetn     (resetn),
         .s_aw       (s_aw[i]),
         .s_aw_valid (s_aw_valid[i]),
         .s_aw_ready (s_aw_ready[i]),
         .s_w        (s_w[i]),
         .s_w_valid  (s_w_valid[i]),
         .s_w_ready  (s_w_ready[i]),
         .s_b        (s_b[i]),
         .s_b_valid  (s_b_valid[i]),
         .s_b_ready  (s_b_ready[i]),
         .s_ar       (s_ar[i]),
         .s_ar_valid (s_ar_valid[i]),
         .s_ar_ready (s_ar_ready[i]),
         .s_r        (s_r[i]),
         .s_r_valid  (s_r_valid[i]),
         .s_r_ready  (s_r_ready[i]),
         .ren        (ren),
         .raddr      (raddr),
         .rdata      (rdata),
         .wen        (wen),
         .waddr      (waddr),
         .wdata      (wdata)
      );

      sram_bank #(
         .DEPTH_WORDS ((2 ** WIN_AW[i]) / 8)
      ) bank_i (
         .clk   (clk),
         .ren   (ren),
         .raddr (raddr),
         .rdata (rdata),
         .wen   (wen),
         .waddr (waddr),
         .wdata (wdata)
      );
   end

endmodule

//--- dv/tb_soc_top.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_top
   import soc_pkg::*;
();

   localparam int CLK_NS    = 4;
   localparam int MAX_WAIT  = 200;
   localparam int TXN_COUNT = 340;
   localparam int WDOG_NS   = (TXN_COUNT * 200 + 20) * CLK_NS;

   localparam logic [31:0] WIN_BASE [3] = '{`SOC_RAM_BASE, `SOC_VGA_BASE, `SOC_PERI_BASE};
   localparam int          WIN_SIZE [3] = '{`SOC_RAM_AW, `SOC_VGA_AW, `SOC_PERI_AW};

   logic    clk;
   logic    resetn;
   axi_aw_t m_aw;
   logic    m_aw_valid;
   logic    m_aw_ready;
   axi_w_t  m_w;
   logic    m_w_valid;
   logic    m_w_ready;
   axi_b_t  m_b;
   logic    m_b_valid;
   logic    m_b_ready;
   axi_ar_t m_ar;
   logic    m_ar_valid;
   logic    m_ar_ready;
   axi_r_t  m_r;
   logic    m_r_valid;
   logic    m_r_ready;

   // reference memory keyed by word address
   logic [63:0] ref_mem [logic [28:0]];
   logic [31:0] rng_state;
   // read presented while a response is held back
   axi_ar_t     probe_ar;

   soc_top dut_i (.*);

   always #(CLK_NS / 2) clk = ~clk;

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
   endtask

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // window index from the address map, -1 when unmapped
   function automatic int window_of(input logic [31:0] addr);
      for (int w = 0; w < 3; w++)
      begin
         if ((addr >> WIN_SIZE[w]) == (WIN_BASE[w] >> WIN_SIZE[w]))
            return w;
      end
      return -1;
   endfunction

   // 16 test slots spread over each window
   function automatic logic [31:0] pool_addr(input int w, input int i);
      return WIN_BASE[w] + 32'(i) * (32'd1 << (WIN_SIZE[w] - 4)) + 32'(i) * 32'd8;
   endfunction

   task automatic ref_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
      logic [63:0] word;
      word = ref_mem.exists(addr[31:3]) ? ref_mem[addr[31:3]] : 64'h0;
      for (int b = 0; b < 8; b++)
      begin
         if (strb[b])
            word[b*8 +: 8] = data[b*8 +: 8];
      end
      ref_mem[addr[31:3]] = word;
   endtask

   task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
      if (got !== exp)
         fail_stop($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_b(input axi_b_t got, input axi_b_t exp);
      if (got.id !== exp.id)
         fail_stop($sformatf("Mismatch m_b.id: got %h expected %h", got.id, exp.id));
      check_resp("m_b.resp", got.resp, exp.resp);
   endtask

   task automatic check_r(input axi_r_t got, input axi_r_t exp);
      if (got.id !== exp.id)
         fail_stop($sformatf("Mismatch m_r.id: got %h expected %h", got.id, exp.id));
      if (got.data !== exp.data)
         fail_stop($sformatf("Mismatch m_r.data: got %h expected %h", got.data, exp.data));
      check_resp("m_r.resp", got.resp, exp.resp);
   endtask

   // entered at a falling edge; returns on the edge that takes the response
   task automatic hold_and_take(input logic is_wr, input int hold,
                                output axi_b_t b, output axi_r_t r);
      int n;
      n = 0;
      #1;
      while (!(is_wr ? m_b_valid : m_r_valid))
      begin
         n++;
         if (n > MAX_WAIT)
            fail_stop("no response from the DUT within the wait limit");
         @(negedge clk);
         #1;
      end
      b = m_b;
      r = m_r;
      for (int k = 0; k < hold; k++)
      begin
         @(negedge clk);
         m_ar       = probe_ar;
         m_ar_valid = 1'b1;
         #1;
         if (!(is_wr ? m_b_valid : m_r_valid))
            fail_stop("response valid dropped while ready was low");
         if (is_wr)
            check_b(m_b, b);
         else
            check_r(m_r, r);
         if (m_ar_ready)
            fail_stop("read request accepted while a response was still held");
      end
      if (hold > 0)
      begin
         @(negedge clk);
         m_b_ready = 1'b1;
         m_r_ready = 1'b1;
      end
      @(posedge clk);
   endtask

   task automatic do_write(input logic [31:0] addr, input logic [3:0] id,
                           input logic [63:0] data, input logic [7:0] strb,
                           input int hold, output axi_b_t b);
      axi_r_t r_unused;
      int     n;
      @(negedge clk);
      m_aw       = '{id: id, addr: addr};
      m_w        = '{data: data, strb: strb};
      m_aw_valid = 1'b1;
      m_w_valid  = 1'b1;
      m_b_ready  = (hold == 0);
      n = 0;
      #1;
      while (!(m_aw_ready && m_w_ready))
      begin
         n++;
         if (n > MAX_WAIT)
            fail_stop("write request was never accepted");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      m_aw_valid = 1'b0;
      m_w_valid  = 1'b0;
      hold_and_take(1'b1, hold, b, r_unused);
   endtask

   task automatic do_read(input logic [31:0] addr, input logic [3:0] id,
                          input int hold, output axi_r_t r);
      axi_b_t b_unused;
      int     n;
      @(negedge clk);
      m_ar       = '{id: id, addr: addr};
      m_ar_valid = 1'b1;
      m_r_ready  = (hold == 0);
      n = 0;
      #1;
      while (!m_ar_ready)
      begin
         n++;
         if (n > MAX_WAIT)
            fail_stop("read request was never accepted");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      m_ar_valid = 1'b0;
      hold_and_take(1'b0, hold, b_unused, r);
   endtask

   task automatic write_and_check(input logic [31:0] addr, input logic [3:0] id,
                                  input logic [63:0] data, input logic [7:0] strb,
                                  input int hold);
      axi_b_t got;
      axi_b_t exp;
      int     w;
      w = window_of(addr);
      do_write(addr, id, data, strb, hold, got);
      exp.id = id;
      if (w < 0)
         exp.resp = DECERR;
      else
         exp.resp = OKAY;
      check_b(got, exp);
      if (w >= 0)
         ref_write(addr, data, strb);
   endtask

   task automatic read_and_check(input logic [31:0] addr, input logic [3:0] id,
                                 input int hold);
      axi_r_t got;
      axi_r_t exp;
      int     w;
      w = window_of(addr);
      exp.id = id;
      if (w < 0)
      begin
         exp.data = 64'h0;
         exp.resp = DECERR;
      end
      else
      begin
         if (!ref_mem.exists(addr[31:3]))
            fail_stop("test reads a location that was never written");
         exp.data = ref_mem[addr[31:3]];
         exp.resp = OKAY;
      end
      do_read(addr, id, hold, got);
      check_r(got, exp);
   endtask

   task automatic reset_idle_outputs();
      for (int c = 0; c < 8; c++)
      begin
         @(negedge clk);
         if (c == 3)
            resetn = 1'b1;
         #1;
         if (m_b_valid || m_r_valid || m_aw_ready || m_w_ready || m_ar_ready)
            fail_stop("handshake output high with no request outstanding");
      end
   endtask

   // full strobe fill of every slot, each read back
   task automatic fill_and_read_back();
      logic [31:0] addr;
      for (int w = 0; w < 3; w++)
      begin
         for (int i = 0; i < 16; i++)
         begin
            addr = pool_addr(w, i);
            write_and_check(addr, next_rand() & 4'hf, {addr, ~addr}, 8'hff, 0);
            read_and_check(addr, next_rand() & 4'hf, 0);
         end
      end
   endtask

   task automatic strobe_merges();
      logic [7:0]  strb_set [2] = '{8'ha5, 8'h0f};
      logic [31:0] d_hi;
      logic [31:0] d_lo;
      for (int w = 0; w < 3; w++)
      begin
         for (int s = 0; s < 2; s++)
         begin
            d_hi = next_rand();
            d_lo = next_rand();
            write_and_check(pool_addr(w, 5), 4'(w + s), {d_hi, d_lo}, strb_set[s], 0);
            read_and_check(pool_addr(w, 5), 4'(w + 4), 0);
         end
      end
   endtask

   task automatic unmapped_accesses();
      logic [31:0] bad [4] = '{32'h0000_0000, 32'h0003_0000, 32'h1c01_0000, 32'h0001_0800};
      for (int k = 0; k < 4; k++)
      begin
         write_and_check(bad[k], 4'(k + 7), 64'hdead_beef_0bad_f00d, 8'hff, 0);
         read_and_check(bad[k], 4'(k + 2), 0);
      end
      for (int w = 0; w < 3; w++)
         read_and_check(pool_addr(w, 0), 4'hc, 0);
   endtask

   task automatic held_responses();
      logic [31:0] addr;
      logic [31:0] d_hi;
      logic [31:0] d_lo;
      logic [3:0]  rid;
      for (int k = 0; k < 6; k++)
      begin
         addr     = pool_addr(k % 3, 9 + k);
         rid      = 4'(next_rand());
         d_hi     = next_rand();
         d_lo     = next_rand();
         probe_ar = '{id: rid, addr: addr};
         write_and_check(addr, 4'(k), {d_hi, d_lo}, 8'hff, int'(next_rand() % 32'd11));
         read_and_check(addr, rid, int'(next_rand() % 32'd11));
         read_and_check(addr, rid, 0);
      end
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      logic [31:0] addr;
      logic [31:0] d_hi;
      logic [31:0] d_lo;
      int          w;
      int          i;
      for (int k = 0; k < 200; k++)
      begin
         r    = next_rand();
         w    = int'(r % 32'd3);
         i    = int'((r >> 4) & 32'hf);
         // low three bits are don't care for the DUT
         addr = pool_addr(w, i) | ((r >> 8) & 32'h7);
         if (r[20])
         begin
            d_hi = next_rand();
            d_lo = next_rand();
            write_and_check(addr, r[15:12], {d_hi, d_lo}, r[31:24], 0);
         end
         else
         begin
            read_and_check(addr, r[15:12], 0);
         end
      end
   endtask

   initial
   begin
      #(WDOG_NS);
      fail_stop("watchdog timeout, tests did not finish in time");
   end

   initial
   begin
      clk        = 1'b0;
      resetn     = 1'b0;
      m_aw       = '0;
      m_aw_valid = 1'b0;
      m_w        = '0;
      m_w_valid  = 1'b0;
      m_b_ready  = 1'b0;
      m_ar       = '0;
      m_ar_valid = 1'b0;
      m_r_ready  = 1'b0;
      probe_ar   = '0;
      rng_state  = 32'd74482;

      reset_idle_outputs();
      fill_and_read_back();
      strobe_merges();
      unmapped_accesses();
      held_responses();
      random_traffic();

      $display("RESULT: PASS");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+common
common/soc_pkg.sv
verilog/sram_bank.sv
sram_bridge/axi_sram_bridge.sv
interconnect/axi_interconnect.sv
verilog/soc_top.sv
dv/tb_soc_top.sv

//--- Makefile
# Verilator flow for the AXI memory fabric

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build tb_soc_top with Verilator and run it"
	@echo "  make clean  remove the build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f \
		--top-module tb_soc_top -o tb_soc_top --Mdir obj_dir
	./obj_dir/tb_soc_top

clean:
	rm -rf obj_dir
